// ==== Makefile ====
# Verilator build and run of the register subsystem testbench
SRCS := $(filter-out +%,$(shell cat sim.f))

obj_dir/Vtb_rcfg: sim.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_rcfg -f sim.f

.PHONY: run clean

run: obj_dir/Vtb_rcfg
	./obj_dir/Vtb_rcfg

clean:
	rm -rf obj_dir

// ==== hw/rcfg_arbiter.sv ====
/*
 * Registered fixed-priority arbiter with bus locking
 * Lowest index wins and keeps the grant while its lock stays high
 */
`timescale 1ns/100ps
`default_nettype none

module rcfg_arbiter import rcfg_pkg::*; (
  input  logic                   reconfig_clk,
  input  logic                   arst_n,
  // One read_write lock per master
  input  logic [NUM_MASTERS-1:0] lock,
  output rcfg_grant_t            grant
);

  // Candidate grant when the bus is free
  rcfg_grant_t pick;
  // Owner still holds its lock
  logic        held;

  // Isolate the lowest set lock bit so the streamer wins
  assign pick = lock & (~lock + 1'b1);

  assign held = |(grant & lock);

  always_ff @(posedge reconfig_clk or negedge arst_n) begin
    if (!arst_n) begin
      grant <= '0;
    end else if (grant == '0) begin
      // Idle bus takes the highest-priority locker (may be none)
      grant <= pick;
    end else if (!held) begin
      // Release at this edge once the owner drops its lock
      grant <= '0;
    end
    // Otherwise keep the owner regardless of other requests
  end

  // Grant never names more than one master
  a_grant_onehot0 : assert property (
    @(posedge reconfig_clk) disable iff (!arst_n)
    $onehot0(grant)
  ) else $error("arbiter grant not one-hot: %b", grant);

endmodule

`default_nettype wire

// ==== hw/rcfg_bus_mux.sv ====
/*
 * Master-to-slave bus multiplexer
 * Runs the arbiter on the lock fields, ORs grant-masked requests
 * onto the slave bus and splits waitrequest back per master
 */
`timescale 1ns/100ps
`default_nettype none

module rcfg_bus_mux import rcfg_pkg::*; (
  input  logic      reconfig_clk,
  input  logic      arst_n,

  // Master requests
  input  rcfg_req_t strm_req,
  input  rcfg_req_t user_req,
  input  rcfg_req_t dbg_req,

  // Per-master back-pressure
  output logic      strm_waitrequest,
  output logic      user_waitrequest,
  output logic      dbg_waitrequest,

  // Slave side
  output rcfg_req_t slave_req,
  input  logic      slave_waitrequest
);

  // Requests indexed by grant bit
  rcfg_req_t                req_vec [NUM_MASTERS];
  logic [NUM_MASTERS-1:0]   lock;
  rcfg_grant_t              grant;

  assign req_vec[0] = strm_req;
  assign req_vec[1] = user_req;
  assign req_vec[2] = dbg_req;

  // Lock order matches priority, streamer in bit 0
  assign lock = {dbg_req.lock, user_req.lock, strm_req.lock};

  rcfg_arbiter u_arbiter (
    .reconfig_clk (reconfig_clk),
    .arst_n       (arst_n),
    .lock         (lock),
    .grant        (grant)
  );

  // Mask each whole request by its grant bit and OR onto the slave
  // At most one grant is set so the OR acts as a select
  always_comb begin
    slave_req = '0;
    for (int i = 0; i < NUM_MASTERS; i++) begin
      slave_req = slave_req | (req_vec[i] & {$bits(rcfg_req_t){grant[i]}});
    end
  end

  // Non-owners always see waitrequest and the owner sees the slave's
  assign {dbg_waitrequest, user_waitrequest, strm_waitrequest} =
    ~grant | {NUM_MASTERS{slave_waitrequest}};

  // Granted master never asks for read and write at once
  a_no_rd_wr : assert property (
    @(posedge reconfig_clk) disable iff (!arst_n)
    !(slave_req.read && slave_req.write)
  ) else $error("slave read and write both high");

endmodule

`default_nettype wire

// ==== hw/rcfg_csr_bank.sv ====
/*
 * Reconfiguration register bank, Avalon-MM slave
 * Two-cycle accesses with read data registered in the first
 * cycle and writes committed on the completing edge
 */
`timescale 1ns/100ps
`default_nettype none

module rcfg_csr_bank import rcfg_pkg::*; (
  input  logic       reconfig_clk,
  input  logic       arst_n,
  input  rcfg_req_t  req,
  output logic       waitrequest,
  output rcfg_data_t readdata
);

  rcfg_data_t             regs [NUM_REGS];
  // High in the first cycle of an access and while idle
  logic                   wait_q;
  logic                   access;
  logic [REG_IDX_W-1:0]   idx;

  assign access = req.read | req.write;

  // Only the low address bits select a word
  assign idx = req.address[REG_IDX_W-1:0];

  assign waitrequest = wait_q;

  always_ff @(posedge reconfig_clk or negedge arst_n) begin
    if (!arst_n) begin
      wait_q   <= 1'b1;
      readdata <= '0;
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (access && wait_q) begin
        // First cycle fetches the word and opens the completing cycle
        wait_q   <= 1'b0;
        readdata <= regs[idx];
      end else begin
        // Completing cycle or idle returns to wait
        wait_q <= 1'b1;
        if (req.write && !wait_q) begin
          regs[idx] <= req.writedata;
        end
      end
    end
  end

  // Master holds its access unchanged across the wait cycle
  a_req_stable : assert property (
    @(posedge reconfig_clk) disable iff (!arst_n)
    access && waitrequest |=>
      access && $stable(req.read) && $stable(req.write) &&
      $stable(req.address) && (!req.write || $stable(req.writedata))
  ) else $error("request changed while waitrequest high");

endmodule

`default_nettype wire

// ==== hw/rcfg_pkg.sv ====
/*
 * Shared definitions for the reconfiguration register subsystem
 * Bus widths, address/data types, master request struct,
 * grant vector, streamer state encoding and profile constants
 */
`default_nettype none

package rcfg_pkg;

  // Avalon-MM bus widths
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  // Three masters: streamer, user, debug
  localparam int NUM_MASTERS = 3;

  // Register bank depth and word select width
  localparam int NUM_REGS  = 32;
  localparam int REG_IDX_W = $clog2(NUM_REGS);

  // Streamer profile table shape
  localparam int PROFILE_LEN    = 4;
  localparam int NUM_PROFILES   = 2;
  localparam int ENTRY_W        = $clog2(PROFILE_LEN);
  localparam int PROFILE_SEL_W  = $clog2(NUM_PROFILES);
  // Address step between profiles, and tag placed in data bits 31:24
  localparam int PROFILE_STRIDE = 8;
  localparam logic [7:0] PROFILE_TAG = 8'hA5;

  typedef logic [ADDR_W-1:0] rcfg_addr_t;
  typedef logic [DATA_W-1:0] rcfg_data_t;

  // Bit 0 streamer, bit 1 user, bit 2 debug
  typedef logic [NUM_MASTERS-1:0] rcfg_grant_t;

  // One master's Avalon-MM request, lock is the read_write hold signal
  typedef struct packed {
    logic       read;
    logic       write;
    logic       lock;
    rcfg_addr_t address;
    rcfg_data_t writedata;
  } rcfg_req_t;

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    DONE
  } strm_state_t;

endpackage

`default_nettype wire

// ==== hw/rcfg_streamer.sv ====
/*
 * Embedded reconfiguration streamer
 * Replays one profile of register writes on a start pulse
 * under a bus lock, then pulses done
 */
`timescale 1ns/100ps
`default_nettype none

module rcfg_streamer import rcfg_pkg::*; (
  input  logic      reconfig_clk,
  input  logic      arst_n,
  input  logic      start,
  input  logic      profile,
  output rcfg_req_t req,
  input  logic      waitrequest,
  output logic      done
);

  strm_state_t              state;
  logic [ENTRY_W-1:0]       entry;
  logic [PROFILE_SEL_W-1:0] profile_q;
  // Current write accepted by the slave
  logic                     accepted;

  assign accepted = (state == WRITE) && !waitrequest;

  always_ff @(posedge reconfig_clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IDLE;
      entry     <= '0;
      profile_q <= '0;
    end else begin
      case (state)
        IDLE: begin
          // Busy states ignore start
          if (start) begin
            profile_q <= profile;
            entry     <= '0;
            state     <= WRITE;
          end
        end
        WRITE: begin
          if (accepted) begin
            if (entry == ENTRY_W'(PROFILE_LEN - 1)) begin
              state <= DONE;
            end else begin
              entry <= entry + 1'b1;
            end
          end
        end
        DONE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Lock and write stay up for the whole profile
  always_comb begin
    req           = '0;
    req.lock      = (state == WRITE);
    req.write     = (state == WRITE);
    // Profile rule: address p*8+k, data {A5, 00, p, k}
    req.address   = rcfg_addr_t'(PROFILE_STRIDE * profile_q + entry);
    req.writedata = {PROFILE_TAG, 8'h00, 8'(profile_q), 8'(entry)};
  end

  // One-cycle pulse after the last write, lock already dropped
  assign done = (state == DONE);

endmodule

`default_nettype wire

// ==== hw/rcfg_top.sv ====
/*
 * Reconfiguration register subsystem top
 * Streamer plus user and debug ports, arbitrated onto
 * one register bank
 */
`timescale 1ns/100ps
`default_nettype none

module rcfg_top import rcfg_pkg::*; (
  input  logic       reconfig_clk,
  input  logic       arst_n,

  // User Avalon-MM port
  input  rcfg_req_t  user_req,
  output logic       user_waitrequest,

  // Debug (JTAG-side) Avalon-MM port
  input  rcfg_req_t  dbg_req,
  output logic       dbg_waitrequest,

  // Shared read data
  output rcfg_data_t readdata,

  // Streamer control
  input  logic       strm_start,
  input  logic       strm_profile,
  output logic       strm_done
);

  // Streamer to mux
  rcfg_req_t strm_req;
  logic      strm_waitrequest;

  // Mux to register bank
  rcfg_req_t slave_req;
  logic      slave_waitrequest;

  rcfg_streamer u_streamer (
    .reconfig_clk (reconfig_clk),
    .arst_n       (arst_n),
    .start        (strm_start),
    .profile      (strm_profile),
    .req          (strm_req),
    .waitrequest  (strm_waitrequest),
    .done         (strm_done)
  );

  // Priority streamer, then user, then debug
  rcfg_bus_mux u_bus_mux (
    .reconfig_clk      (reconfig_clk),
    .arst_n            (arst_n),
    .strm_req          (strm_req),
    .user_req          (user_req),
    .dbg_req           (dbg_req),
    .strm_waitrequest  (strm_waitrequest),
    .user_waitrequest  (user_waitrequest),
    .dbg_waitrequest   (dbg_waitrequest),
    .slave_req         (slave_req),
    .slave_waitrequest (slave_waitrequest)
  );

  rcfg_csr_bank u_csr_bank (
    .reconfig_clk (reconfig_clk),
    .arst_n       (arst_n),
    .req          (slave_req),
    .waitrequest  (slave_waitrequest),
    .readdata     (readdata)
  );

endmodule

`default_nettype wire

// ==== sim.f ====
hw/rcfg_pkg.sv
hw/rcfg_arbiter.sv
hw/rcfg_bus_mux.sv
hw/rcfg_streamer.sv
hw/rcfg_csr_bank.sv
hw/rcfg_top.sv
verif/tb_rcfg.sv

// ==== verif/tb_rcfg.sv ====
/*
 * Testbench for the reconfiguration register subsystem
 * Shadow-register reference model, port and streamer stimulus,
 * read compare process, ownership monitor and watchdog
 */
`timescale 1ns/100ps
`default_nettype none

module tb_rcfg import rcfg_pkg::*; ();

  // Reset, two user groups, two debug groups, streamer profiles and readbacks
  localparam int PLANNED_ACCESSES = 76;

  typedef struct packed {
    logic       rd;
    rcfg_addr_t addr;
    rcfg_data_t data;
  } op_t;

  logic       clk;
  logic       arst_n;
  rcfg_req_t  user_req;
  rcfg_req_t  dbg_req;
  logic       user_waitrequest;
  logic       dbg_waitrequest;
  rcfg_data_t readdata;
  logic       strm_start;
  logic       strm_profile;
  logic       strm_done;

  // Expected bank contents updated on every completed write
  rcfg_data_t shadow [NUM_REGS];
  op_t        user_ops [$];
  op_t        dbg_ops [$];
  rcfg_data_t exp_q [$];
  rcfg_data_t got_q [$];
  rcfg_addr_t addrs [$];
  // Set while a user group holds the bus
  logic       user_owns;

  rcfg_top UUT (
    .reconfig_clk     (clk),
    .arst_n           (arst_n),
    .user_req         (user_req),
    .user_waitrequest (user_waitrequest),
    .dbg_req          (dbg_req),
    .dbg_waitrequest  (dbg_waitrequest),
    .readdata         (readdata),
    .strm_start       (strm_start),
    .strm_profile     (strm_profile),
    .strm_done        (strm_done)
  );

  always #2 clk = ~clk;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // Profile rule for entry k of profile p
  function automatic rcfg_addr_t profile_addr(input int p, input int k);
    return rcfg_addr_t'(PROFILE_STRIDE * p + k);
  endfunction

  // Tag A5 on top, profile in bits 15:8 and entry in bits 7:0
  function automatic rcfg_data_t profile_word(input int p, input int k);
    return 32'hA500_0000 | (32'(p) << 8) | 32'(k);
  endfunction

  // Expected word at the address, selected by its low bits
  function automatic rcfg_data_t expected_word(input rcfg_addr_t addr);
    return shadow[addr[REG_IDX_W-1:0]];
  endfunction

  function automatic logic port_wait(input bit is_dbg);
    return is_dbg ? dbg_waitrequest : user_waitrequest;
  endfunction

  function automatic rcfg_addr_t rand_addr();
    return rcfg_addr_t'($urandom_range(0, 255));
  endfunction

  task automatic add_op(input bit is_dbg, input bit rd, input rcfg_addr_t addr,
                        input rcfg_data_t data);
    op_t op;
    op.rd   = rd;
    op.addr = addr;
    op.data = data;
    if (is_dbg) dbg_ops.push_back(op);
    else user_ops.push_back(op);
  endtask

  task automatic drive_port(input bit is_dbg, input rcfg_req_t r);
    if (is_dbg) dbg_req <= r;
    else user_req <= r;
  endtask

  // One locked group of back-to-back accesses from the queued ops
  task automatic run_group(input bit is_dbg);
    op_t       op;
    rcfg_req_t r;
    int        n;
    n = is_dbg ? dbg_ops.size() : user_ops.size();
    @(posedge clk);
    for (int i = 0; i < n; i++) begin
      op          = is_dbg ? dbg_ops[i] : user_ops[i];
      r           = '0;
      r.lock      = 1'b1;
      r.read      = op.rd;
      r.write     = !op.rd;
      r.address   = op.addr;
      r.writedata = op.data;
      drive_port(is_dbg, r);
      // Hold until this port's waitrequest drops
      do begin
        @(negedge clk);
      end while (port_wait(is_dbg));
      if (op.rd) begin
        exp_q.push_back(expected_word(op.addr));
        got_q.push_back(readdata);
      end else begin
        shadow[op.addr[REG_IDX_W-1:0]] = op.data;
      end
      @(posedge clk);
    end
    // Release the lock
    drive_port(is_dbg, '0);
    if (is_dbg) dbg_ops.delete();
    else user_ops.delete();
  endtask

  task automatic pulse_start(input int p);
    @(posedge clk);
    strm_profile <= 1'(p);
    strm_start   <= 1'b1;
    @(posedge clk);
    strm_start   <= 1'b0;
  endtask

  // Fold the finished profile into the shadow
  task automatic wait_done(input int p);
    do begin
      @(negedge clk);
    end while (!strm_done);
    for (int k = 0; k < PROFILE_LEN; k++) begin
      shadow[profile_addr(p, k)] = profile_word(p, k);
    end
  endtask

  // Read compare
  always @(negedge clk) begin
    while (got_q.size() > 0) begin
      check("readdata", got_q.pop_front(), exp_q.pop_front());
    end
  end

  // Debug and streamer stay off the bus while the user holds it
  always @(negedge clk) begin
    if (user_owns) begin
      check("dbg_waitrequest", 32'(dbg_waitrequest), 32'd1);
      check("strm_done", 32'(strm_done), 32'd0);
    end
  end

  initial begin
    repeat (16 + 200 * PLANNED_ACCESSES) @(posedge clk);
    $display("Watchdog expired: the DUT stopped responding before the tests finished");
    $display("TEST FAILED");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    user_req     = '0;
    dbg_req      = '0;
    strm_start   = 1'b0;
    strm_profile = 1'b0;
    user_owns    = 1'b0;
    for (int i = 0; i < NUM_REGS; i++) begin
      shadow[i] = '0;
    end
    void'($urandom(65));
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    // Idle bus and zeroed bank after reset
    @(negedge clk);
    check("user_waitrequest", 32'(user_waitrequest), 32'd1);
    check("dbg_waitrequest", 32'(dbg_waitrequest), 32'd1);
    for (int i = 0; i < 4; i++) add_op(1'b0, 1'b1, rand_addr(), '0);
    run_group(1'b0);

    // Random writes and readbacks through the user port and then the debug port
    for (int port = 0; port < 2; port++) begin
      addrs.delete();
      for (int i = 0; i < 6; i++) begin
        addrs.push_back(rand_addr());
        add_op(port == 1, 1'b0, addrs[i], $urandom());
      end
      foreach (addrs[i]) add_op(port == 1, 1'b1, addrs[i], '0);
      run_group(port == 1);
    end

    // Both profiles followed by readback of their words
    pulse_start(0);
    wait_done(0);
    pulse_start(1);
    wait_done(1);
    for (int p = 0; p < NUM_PROFILES; p++) begin
      for (int k = 0; k < PROFILE_LEN; k++) add_op(1'b0, 1'b1, profile_addr(p, k), '0);
    end
    run_group(1'b0);

    // User and debug lock in the same cycle and the user wins
    addrs.delete();
    for (int i = 0; i < 4; i++) begin
      addrs.push_back(rand_addr());
      add_op(1'b0, 1'b0, addrs[2*i], $urandom());
      addrs.push_back(rand_addr());
      add_op(1'b1, 1'b0, addrs[2*i+1], $urandom());
    end
    fork
      begin
        user_owns = 1'b1;
        run_group(1'b0);
        user_owns = 1'b0;
      end
      run_group(1'b1);
    join
    foreach (addrs[i]) add_op(1'b0, 1'b1, addrs[i], '0);
    run_group(1'b0);

    // Streamer started inside a user group must wait for the release
    for (int k = 0; k < PROFILE_LEN; k++) add_op(1'b0, 1'b0, profile_addr(0, k), $urandom());
    for (int k = 0; k < PROFILE_LEN; k++) add_op(1'b0, 1'b1, profile_addr(0, k), '0);
    fork
      begin
        user_owns = 1'b1;
        run_group(1'b0);
        user_owns = 1'b0;
      end
      begin
        repeat (6) @(posedge clk);
        pulse_start(0);
      end
    join
    wait_done(0);
    for (int k = 0; k < PROFILE_LEN; k++) add_op(1'b0, 1'b1, profile_addr(0, k), '0);
    run_group(1'b0);

    // Let the compare process drain
    repeat (2) @(negedge clk);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire
